// File: sim/regex_trace.txt
# T name | W paddr data pslverr | R paddr data pslverr | P status | N paddr | S paddr | E
# hex values; P polls until not running, N reads non-zero, S reads same as the read before
T registers
W 00 12345678 0
W 04 0000001f 0
W 08 000000a5 0
R 00 12345678 0
R 04 0000001f 0
R 08 000000a5 0
R 0c 00000000 0
R 10 00000000 0
R 1c 00000000 1
W 10 00000001 1
E
# address moves before data while the write command is held
T memory_lanes
W 04 00000020 0
W 00 cafef00d 0
W 0c 00000001 0
W 04 00000021 0
W 00 0badbeef 0
W 0c 00000002 0
R 14 0badbeef 0
W 04 00000020 0
R 14 cafef00d 0
E
# program char 'a', any, end; text "ab" at byte 40, "ca" at byte 44
T match
W 04 00000000 0
W 00 01000061 0
W 0c 00000001 0
W 04 00000001 0
W 00 02000000 0
W 04 00000002 0
W 00 03000000 0
W 04 00000010 0
W 00 00006261 0
W 04 00000011 0
W 00 00006163 0
W 08 00000040 0
W 0c 00000003 0
P 00000002
E
T reject_error
W 0c 00000004 0
R 10 00000000 0
W 08 00000044 0
W 0c 00000003 0
P 00000003
W 0c 00000004 0
R 10 00000000 0
W 04 00000000 0
W 00 09000000 0
W 0c 00000001 0
W 0c 00000003 0
P 00000004
E
T counter_reset
W 0c 00000005 0
N 14
S 14
W 0c 00000006 0
R 10 00000000 0
W 0c 00000005 0
R 14 00000000 0
E

// File: src.f
src/regex_pkg.sv
src/regex_mem.sv
src/apb_cmd_regs.sv
src/cmd_controller.sv
src/mem_arbiter.sv
src/regex_engine.sv
src/regex_top.sv
sim/regex_checker.sv
sim/regex_tb.sv

// File: Makefile
TOP := regex_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module $(TOP) \
		-Mdir obj_dir -o regex_sim
	./obj_dir/regex_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/regex_tb.sv
module regex_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import regex_pkg::*;

    logic                      clk = 1'b0;
    logic                      reset_master;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [REG_WIDTH-1:0]      pwdata;
    logic [REG_WIDTH-1:0]      prdata;
    logic                      pready;
    logic                      pslverr;
    int                        error_count;
    logic                      timed_out;
    string                     lines[$];  // whole trace, one entry per line

    always #2 clk = ~clk;  // 4 ns period

    regex_top regex_top_i (.*);

    regex_checker regex_checker_i (.*);

    //////////////////////////////////////////////////////////////////////
    // apb driver

    // setup, access, then idle; read data taken mid access phase
    task automatic apb_transfer(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                                input logic [REG_WIDTH-1:0] data,
                                output logic [REG_WIDTH-1:0] rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic string drop_line_end(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r"))
            t = t.substr(0, t.len() - 2);
        return t;
    endfunction

    task automatic read_trace();
        int    fd;
        string line;
        fd = $fopen("sim/regex_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open sim/regex_trace.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
            lines.push_back(drop_line_end(line));
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // trace playback

    task automatic play_line(input string line);
        logic [REG_WIDTH-1:0] addr;
        logic [REG_WIDTH-1:0] data;
        logic [REG_WIDTH-1:0] err;
        logic [REG_WIDTH-1:0] rdata;
        int                   tries;
        case (line.getc(0))
            "T": regex_checker_i.open_test(line.substr(2, line.len() - 1));
            "E": regex_checker_i.close_test();
            "W":
            begin
                void'($sscanf(line, "W %h %h %h", addr, data, err));
                regex_checker_i.expect_slverr(err[0]);
                apb_transfer(1'b1, addr[APB_ADDR_WIDTH-1:0], data, rdata);
            end
            "R":
            begin
                void'($sscanf(line, "R %h %h %h", addr, data, err));
                regex_checker_i.expect_value(data, err[0]);
                apb_transfer(1'b0, addr[APB_ADDR_WIDTH-1:0], '0, rdata);
            end
            "N", "S":
            begin
                void'($sscanf(line.substr(2, line.len() - 1), "%h", addr));
                if (line.getc(0) == "N")
                    regex_checker_i.expect_nonzero();
                else
                    regex_checker_i.expect_repeat();
                apb_transfer(1'b0, addr[APB_ADDR_WIDTH-1:0], '0, rdata);
            end
            "P":
            begin
                void'($sscanf(line, "P %h", data));
                tries = 0;
                rdata = STATUS_RUNNING;
                while (rdata == STATUS_RUNNING && tries < 100)  // about 300 cycles
                begin
                    apb_transfer(1'b0, {REG_STATUS, 2'b00}, '0, rdata);
                    tries++;
                end
                if (rdata == STATUS_RUNNING)
                    regex_checker_i.note_stuck_poll();
                regex_checker_i.expect_value(data, 1'b0);
                apb_transfer(1'b0, {REG_STATUS, 2'b00}, '0, rdata);
            end
            default: ;  // comment or blank line
        endcase
    endtask

    initial
    begin
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        reset_master = 1'b1;
        read_trace();
        regex_checker_i.arm_timeout(lines.size() * 200);
        repeat (5) @(posedge clk);
        #1;
        reset_master = 1'b0;
        foreach (lines[i])
            play_line(lines[i]);
        regex_checker_i.print_totals();
        if (lines.size() != 0 && error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        wait (timed_out);
        $display("tests failed");
        $finish;
    end

endmodule

// File: sim/regex_checker.sv
module regex_checker (
    input  logic                                 clk,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pready,
    input  logic                                 pslverr,
    input  logic [regex_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [regex_pkg::REG_WIDTH-1:0]      prdata,
    output int                                   error_count,
    output logic                                 timed_out
);
    timeunit 1ns;
    timeprecision 100ps;
    import regex_pkg::*;

    typedef enum int {MATCH_NONE, MATCH_EQUAL, MATCH_NONZERO, MATCH_LAST} match_e;

    match_e               mode        = MATCH_NONE;
    logic [REG_WIDTH-1:0] exp_data    = '0;
    logic                 exp_err     = 1'b0;
    int                   exp_seq     = 0;  // bumped per expected transfer
    int                   done_seq    = 0;
    logic [REG_WIDTH-1:0] last_data   = '0;
    int                   mismatches  = 0;
    int                   stuck_polls = 0;
    int                   test_base   = 0;
    int                   tests_run   = 0;
    int                   tests_bad   = 0;
    string                test_name   = "";
    int                   cycles      = 0;
    int                   limit       = 0;  // zero until armed

    assign error_count = mismatches + stuck_polls;
    assign timed_out   = limit > 0 && cycles >= limit;

    //////////////////////////////////////////////////////////////////////
    // expectations from the driver

    task automatic expect_value(input logic [REG_WIDTH-1:0] data, input logic err);
        mode     = MATCH_EQUAL;
        exp_data = data;
        exp_err  = err;
        exp_seq++;
    endtask

    task automatic expect_slverr(input logic err);
        mode    = MATCH_NONE;
        exp_err = err;
        exp_seq++;
    endtask

    task automatic expect_nonzero();
        mode    = MATCH_NONZERO;
        exp_err = 1'b0;
        exp_seq++;
    endtask

    task automatic expect_repeat();
        mode    = MATCH_LAST;
        exp_err = 1'b0;
        exp_seq++;
    endtask

    task automatic report_value(input string name, input logic [REG_WIDTH-1:0] expected,
                                input logic [REG_WIDTH-1:0] actual);
        $display("Error: %s at paddr %h expected %h got %h", name, paddr, expected, actual);
        mismatches++;
    endtask

    // access phase is settled by the falling edge
    always @(negedge clk)
    begin
        if (psel && penable && exp_seq != done_seq)
        begin
            done_seq = exp_seq;
            if (pready !== 1'b1)
                report_value("pready", {31'b0, 1'b1}, {31'b0, pready});
            if (pslverr !== exp_err)
                report_value("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
            if (mode == MATCH_EQUAL && prdata !== exp_data)
                report_value("prdata", exp_data, prdata);
            if (mode == MATCH_NONZERO && prdata === '0)
            begin
                $display("Error: prdata at paddr %h expected non-zero got %h", paddr, prdata);
                mismatches++;
            end
            if (mode == MATCH_LAST && prdata !== last_data)
                report_value("prdata", last_data, prdata);
            if (mode != MATCH_NONE)
                last_data = prdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test bookkeeping and timeout

    task automatic open_test(input string name);
        test_name = name;
        test_base = mismatches + stuck_polls;
    endtask

    task automatic close_test();
        int errs;
        errs = mismatches + stuck_polls - test_base;
        tests_run++;
        if (errs == 0)
            $display("test %s: ok", test_name);
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    task automatic note_stuck_poll();
        $display("status never left running in test %s", test_name);
        stuck_polls++;
    endtask

    task automatic print_totals();
        $display("%0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, mismatches + stuck_polls);
    endtask

    task automatic arm_timeout(input int max_cycles);
        limit = max_cycles;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles == limit)
            $display("timeout after %0d cycles, trace did not reach its end", cycles);
    end

endmodule

// File: src/regex_top.sv
module regex_top (
    input  logic                                 clk,
    input  logic                                 reset_master,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [regex_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [regex_pkg::REG_WIDTH-1:0]      pwdata,
    output logic [regex_pkg::REG_WIDTH-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr
);
    import regex_pkg::*;

    // register file and controller
    logic [REG_WIDTH-1:0]        data_in;
    logic [REG_WIDTH-1:0]        address;
    logic [REG_WIDTH-1:0]        start_ptr;
    logic [REG_WIDTH-1:0]        cmd;
    logic [REG_WIDTH-1:0]        status;
    logic [REG_WIDTH-1:0]        data_out;

    // controller and engine
    logic                        engine_clear;
    logic                        start_ready;
    logic                        start_valid;
    logic                        finish;
    logic                        accept;
    logic                        error;

    // memory side
    logic                        host_req;
    logic [MEM_R_ADDR_WIDTH-1:0] host_addr;
    logic                        host_rvalid;
    logic                        eng_req;
    logic [MEM_R_ADDR_WIDTH-1:0] eng_addr;
    logic                        eng_ready;
    logic                        eng_rvalid;
    logic                        mem_r_valid;
    logic [MEM_R_ADDR_WIDTH-1:0] mem_r_addr;
    logic [MEM_R_WIDTH-1:0]      mem_r_data;
    logic                        mem_w_valid;
    logic [MEM_W_ADDR_WIDTH-1:0] mem_w_addr;
    logic [MEM_W_WIDTH-1:0]      mem_w_data;

    apb_cmd_regs apb_cmd_regs_i (.*);

    cmd_controller cmd_controller_i (.*);

    mem_arbiter mem_arbiter_i (.*);

    regex_mem regex_mem_i (
        .clk     (clk),
        .w_valid (mem_w_valid),
        .w_addr  (mem_w_addr),
        .w_data  (mem_w_data),
        .r_valid (mem_r_valid),
        .r_addr  (mem_r_addr),
        .r_data  (mem_r_data)
    );

    regex_engine regex_engine_i (
        .mem_r_data (mem_r_data),
        .*
    );

endmodule

// File: src/regex_engine.sv
module regex_engine (
    input  logic                                   clk,
    input  logic                                   reset_master,
    input  logic                                   engine_clear,
    input  logic                                   start_ready,
    input  logic [regex_pkg::REG_WIDTH-1:0]        start_ptr,
    output logic                                   start_valid,
    output logic                                   eng_req,
    output logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] eng_addr,
    input  logic                                   eng_ready,
    input  logic                                   eng_rvalid,
    input  regex_pkg::mem_word_u                   mem_r_data,
    output logic                                   finish,
    output logic                                   accept,
    output logic                                   error
);
    import regex_pkg::*;

    logic                                       busy;
    logic                                       fetch_char;  // 0 instruction, 1 character
    logic                                       waiting;     // read in flight
    logic                                       rdone;
    logic [PC_WIDTH-1:0]                        pc;
    logic [CHAR_SEL_WIDTH+MEM_R_ADDR_WIDTH-1:0] text_ptr;    // byte address
    logic [CHAR_WIDTH-1:0]                      op_q;
    logic [CHAR_WIDTH-1:0]                      lit_q;
    logic [REG_WIDTH-1:0]                       cur_instr;
    logic [CHAR_WIDTH-1:0]                      cur_op;
    logic [CHAR_WIDTH-1:0]                      cur_char;
    logic                                       char_ok;

    assign start_valid = start_ready && !busy;
    assign eng_req     = busy && !waiting;  // held until accepted
    assign rdone       = eng_rvalid && waiting;
    assign eng_addr    = fetch_char ? text_ptr[CHAR_SEL_WIDTH +: MEM_R_ADDR_WIDTH]
                                    : MEM_R_ADDR_WIDTH'(pc[PC_WIDTH-1:LANE_SEL_WIDTH]);

    // same word seen as instructions or as characters
    assign cur_instr = mem_r_data.instr[pc[LANE_SEL_WIDTH-1:0]];
    assign cur_op    = cur_instr[REG_WIDTH-1 -: CHAR_WIDTH];
    assign cur_char  = mem_r_data.chars[text_ptr[CHAR_SEL_WIDTH-1:0]];

    always_comb
    begin
        case (op_q)
            OP_CHAR: char_ok = cur_char == lit_q;
            OP_ANY:  char_ok = cur_char != '0;
            OP_END:  char_ok = cur_char == '0;
            default: char_ok = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // control, finish and error are single pulses

    always_ff @(posedge clk)
    begin
        if (reset_master || engine_clear)
        begin
            busy       <= 1'b0;
            fetch_char <= 1'b0;
            waiting    <= 1'b0;
            finish     <= 1'b0;
            accept     <= 1'b0;
            error      <= 1'b0;
        end
        else
        begin
            finish <= 1'b0;
            accept <= 1'b0;
            error  <= 1'b0;
            if (start_valid)
            begin
                busy       <= 1'b1;
                fetch_char <= 1'b0;
            end
            else if (eng_req && eng_ready)
            begin
                waiting <= 1'b1;
            end
            else if (rdone)
            begin
                waiting <= 1'b0;
                if (!fetch_char)
                begin
                    case (cur_op)
                        OP_CHAR, OP_ANY, OP_END: fetch_char <= 1'b1;
                        OP_ACCEPT:
                        begin
                            finish <= 1'b1;
                            accept <= 1'b1;
                            busy   <= 1'b0;
                        end
                        default:
                        begin
                            error <= 1'b1;  // unknown opcode
                            busy  <= 1'b0;
                        end
                    endcase
                end
                else
                begin
                    fetch_char <= 1'b0;
                    if (!char_ok || op_q == OP_END)
                    begin
                        finish <= 1'b1;
                        accept <= char_ok;  // end of text matched
                        busy   <= 1'b0;
                    end
                    else if (&pc)
                    begin
                        error <= 1'b1;  // pc would wrap
                        busy  <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_valid)
        begin
            pc       <= '0;
            text_ptr <= start_ptr[$bits(text_ptr)-1:0];
        end
        else if (rdone && !fetch_char)
        begin
            op_q  <= cur_op;
            lit_q <= cur_instr[CHAR_WIDTH-1:0];
        end
        else if (rdone && char_ok)
        begin
            pc       <= pc + 1'b1;  // next instruction and next char
            text_ptr <= text_ptr + 1'b1;
        end
    end

endmodule

// File: src/mem_arbiter.sv
module mem_arbiter (
    input  logic                                   clk,
    input  logic                                   reset_master,
    input  logic                                   host_req,
    input  logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] host_addr,
    input  logic                                   eng_req,
    input  logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] eng_addr,
    output logic                                   eng_ready,
    output logic                                   host_rvalid,
    output logic                                   eng_rvalid,
    output logic                                   mem_r_valid,
    output logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] mem_r_addr
);
    logic eng_grant;
    logic host_grant;

    assign eng_ready   = 1'b1;  // engine always wins the port
    assign eng_grant   = eng_req && eng_ready;
    assign host_grant  = host_req && !eng_req;
    assign mem_r_valid = eng_grant || host_grant;
    assign mem_r_addr  = eng_req ? eng_addr : host_addr;

    // remember the owner for the returning data
    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            eng_rvalid  <= 1'b0;
            host_rvalid <= 1'b0;
        end
        else
        begin
            eng_rvalid  <= eng_grant;
            host_rvalid <= host_grant;
        end
    end

    // one engine read in flight, the host gets the gap
    a_one_engine_read: assert property (@(posedge clk) disable iff (reset_master)
        eng_rvalid |-> !eng_req);

endmodule

// File: src/cmd_controller.sv
module cmd_controller (
    input  logic                                   clk,
    input  logic                                   reset_master,
    input  logic [regex_pkg::REG_WIDTH-1:0]        data_in,
    input  logic [regex_pkg::REG_WIDTH-1:0]        address,
    input  logic [regex_pkg::REG_WIDTH-1:0]        cmd,
    output logic [regex_pkg::REG_WIDTH-1:0]        status,
    output logic [regex_pkg::REG_WIDTH-1:0]        data_out,
    output logic                                   engine_clear,
    output logic                                   start_ready,
    output logic                                   host_req,
    output logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] host_addr,
    output logic                                   mem_w_valid,
    output logic [regex_pkg::MEM_W_ADDR_WIDTH-1:0] mem_w_addr,
    output logic [regex_pkg::MEM_W_WIDTH-1:0]      mem_w_data,
    input  logic                                   host_rvalid,
    input  logic [regex_pkg::MEM_R_WIDTH-1:0]      mem_r_data,
    input  logic                                   start_valid,
    input  logic                                   finish,
    input  logic                                   accept,
    input  logic                                   error
);
    import regex_pkg::*;

    logic                 clear;      // hard or soft reset
    logic                 running;
    logic                 started;
    logic [REG_WIDTH-1:0] elapsed;
    logic [REG_WIDTH-1:0] host_sel;
    logic [REG_WIDTH-1:0] host_word;  // selected half of the last host read

    assign engine_clear = cmd == CMD_RESET;
    assign clear        = reset_master || engine_clear;
    assign running      = status == STATUS_RUNNING;
    assign start_ready  = status == STATUS_IDLE && cmd == CMD_START;
    assign started      = start_ready && start_valid;

    // host side of the memory while the engine is not running
    assign mem_w_valid = !running && cmd == CMD_WRITE;
    assign mem_w_addr  = address[MEM_W_ADDR_WIDTH-1:0];
    assign mem_w_data  = data_in[MEM_W_WIDTH-1:0];
    assign host_req    = !running && cmd == CMD_READ;
    assign host_addr   = address[LANE_SEL_WIDTH +: MEM_R_ADDR_WIDTH];
    assign host_sel    = mem_r_data[address[LANE_SEL_WIDTH-1:0] * REG_WIDTH +: REG_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // status machine

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            status <= STATUS_IDLE;
        end
        else
        begin
            case (status)
                STATUS_IDLE:
                begin
                    if (started)
                        status <= STATUS_RUNNING;
                end
                STATUS_RUNNING:
                begin
                    if (error)
                        status <= STATUS_ERROR;
                    else if (finish)
                        status <= accept ? STATUS_ACCEPTED : STATUS_REJECTED;
                end
                STATUS_ACCEPTED, STATUS_REJECTED, STATUS_ERROR:
                begin
                    if (cmd == CMD_RESTART)
                        status <= STATUS_IDLE;
                end
                default: status <= STATUS_IDLE;
            endcase
        end
    end

    // running cycles saturate at all ones
    always_ff @(posedge clk)
    begin
        if (clear || started)
            elapsed <= '0;
        else if (running && !(&elapsed))
            elapsed <= elapsed + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (host_rvalid)
            host_word <= host_sel;
    end

    always_comb
    begin
        case (cmd)
            CMD_READ:         data_out = host_rvalid ? host_sel : host_word;
            CMD_READ_ELAPSED: data_out = elapsed;
            default:          data_out = '0;
        endcase
    end

    // engine reports only during a run
    a_report_while_running: assert property (@(posedge clk) disable iff (clear)
        (finish || error) |-> running);

endmodule

// File: src/apb_cmd_regs.sv
module apb_cmd_regs (
    input  logic                                 clk,
    input  logic                                 reset_master,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [regex_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [regex_pkg::REG_WIDTH-1:0]      pwdata,
    output logic [regex_pkg::REG_WIDTH-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [regex_pkg::REG_WIDTH-1:0]      data_in,
    output logic [regex_pkg::REG_WIDTH-1:0]      address,
    output logic [regex_pkg::REG_WIDTH-1:0]      start_ptr,
    output logic [regex_pkg::REG_WIDTH-1:0]      cmd,
    input  logic [regex_pkg::REG_WIDTH-1:0]      status,
    input  logic [regex_pkg::REG_WIDTH-1:0]      data_out
);
    import regex_pkg::*;

    logic [REG_OFF_WIDTH-1:0] offset;
    logic                     access;
    logic                     bad_addr;
    logic                     read_only;
    logic                     wr_en;

    assign offset    = paddr[APB_ADDR_WIDTH-1 -: REG_OFF_WIDTH];
    assign access    = psel && penable;
    assign bad_addr  = paddr[1:0] != 2'b00 || offset > REG_DATA_OUT;  // misaligned or unmapped
    assign read_only = offset == REG_STATUS || offset == REG_DATA_OUT;

    assign pready  = access;  // no wait states
    assign pslverr = access && (bad_addr || (pwrite && read_only));
    assign wr_en   = access && pwrite && !pslverr;

    //////////////////////////////////////////////////////////////////////
    // writable registers

    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            cmd <= CMD_NOP;
        end
        else if (wr_en && offset == REG_CMD)
        begin
            cmd <= pwdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (offset)
                REG_DATA_IN:   data_in   <= pwdata;
                REG_ADDRESS:   address   <= pwdata;
                REG_START_PTR: start_ptr <= pwdata;
                default:       ;  // cmd handled above
            endcase
        end
    end

    // read mux
    always_comb
    begin
        case (offset)
            REG_DATA_IN:   prdata = data_in;
            REG_ADDRESS:   prdata = address;
            REG_START_PTR: prdata = start_ptr;
            REG_CMD:       prdata = cmd;
            REG_STATUS:    prdata = status;
            REG_DATA_OUT:  prdata = data_out;
            default:       prdata = '0;
        endcase
    end

    // every access phase follows its setup phase
    a_pready_after_setup: assert property (@(posedge clk) disable iff (reset_master)
        pready |-> $past(psel && !penable));

endmodule

// File: src/regex_mem.sv
module regex_mem (
    input  logic                                   clk,
    input  logic                                   w_valid,
    input  logic [regex_pkg::MEM_W_ADDR_WIDTH-1:0] w_addr,
    input  logic [regex_pkg::MEM_W_WIDTH-1:0]      w_data,
    input  logic                                   r_valid,
    input  logic [regex_pkg::MEM_R_ADDR_WIDTH-1:0] r_addr,
    output logic [regex_pkg::MEM_R_WIDTH-1:0]      r_data
);
    import regex_pkg::*;

    // two write words per entry, even write address in the low half
    logic [MEM_R_WIDTH/MEM_W_WIDTH-1:0][MEM_W_WIDTH-1:0] mem [2**MEM_R_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (w_valid)
        begin
            mem[w_addr[MEM_W_ADDR_WIDTH-1:LANE_SEL_WIDTH]][w_addr[LANE_SEL_WIDTH-1:0]] <= w_data;
        end
        if (r_valid)
        begin
            r_data <= mem[r_addr];  // data one cycle after the request
        end
    end

endmodule

// File: src/regex_pkg.sv
package regex_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    localparam int REG_WIDTH        = 32;  // apb data and registers
    localparam int REG_OFF_WIDTH    = 3;   // word offset on paddr[4:2]
    localparam int APB_ADDR_WIDTH   = REG_OFF_WIDTH + 2;
    localparam int MEM_R_WIDTH      = 64;
    localparam int MEM_R_ADDR_WIDTH = 9;
    localparam int MEM_W_WIDTH      = 32;
    localparam int MEM_W_ADDR_WIDTH = 10;
    localparam int LANE_SEL_WIDTH   = 1;   // which 32-bit half of a read word
    localparam int CHAR_WIDTH       = 8;
    localparam int CHAR_SEL_WIDTH   = $clog2(MEM_R_WIDTH / CHAR_WIDTH);
    localparam int PC_WIDTH         = 8;

    //////////////////////////////////////////////////////////////////////
    // commands and status, one word each

    localparam logic [REG_WIDTH-1:0] CMD_NOP          = 0;
    localparam logic [REG_WIDTH-1:0] CMD_WRITE        = 1;
    localparam logic [REG_WIDTH-1:0] CMD_READ         = 2;
    localparam logic [REG_WIDTH-1:0] CMD_START        = 3;
    localparam logic [REG_WIDTH-1:0] CMD_RESTART      = 4;
    localparam logic [REG_WIDTH-1:0] CMD_READ_ELAPSED = 5;
    localparam logic [REG_WIDTH-1:0] CMD_RESET        = 6;

    localparam logic [REG_WIDTH-1:0] STATUS_IDLE      = 0;
    localparam logic [REG_WIDTH-1:0] STATUS_RUNNING   = 1;
    localparam logic [REG_WIDTH-1:0] STATUS_ACCEPTED  = 2;
    localparam logic [REG_WIDTH-1:0] STATUS_REJECTED  = 3;
    localparam logic [REG_WIDTH-1:0] STATUS_ERROR     = 4;

    // register map, word offsets
    localparam logic [REG_OFF_WIDTH-1:0] REG_DATA_IN   = 0;
    localparam logic [REG_OFF_WIDTH-1:0] REG_ADDRESS   = 1;
    localparam logic [REG_OFF_WIDTH-1:0] REG_START_PTR = 2;
    localparam logic [REG_OFF_WIDTH-1:0] REG_CMD       = 3;
    localparam logic [REG_OFF_WIDTH-1:0] REG_STATUS    = 4;  // read only
    localparam logic [REG_OFF_WIDTH-1:0] REG_DATA_OUT  = 5;  // read only

    // opcode sits in the top byte of an instruction
    localparam logic [CHAR_WIDTH-1:0] OP_CHAR   = 1;
    localparam logic [CHAR_WIDTH-1:0] OP_ANY    = 2;
    localparam logic [CHAR_WIDTH-1:0] OP_END    = 3;
    localparam logic [CHAR_WIDTH-1:0] OP_ACCEPT = 4;

    // lower address in the low half or low byte
    typedef union packed {
        logic [MEM_R_WIDTH/REG_WIDTH-1:0][REG_WIDTH-1:0]   instr;
        logic [MEM_R_WIDTH/CHAR_WIDTH-1:0][CHAR_WIDTH-1:0] chars;
    } mem_word_u;

endpackage
